/* design/gf_pkg.sv */
//------------------------------
// GF(2^4) field definitions
// element type, field product and alpha powers
//------------------------------
package gf_pkg;

  // field width and code length
  localparam int m      = 4;
  localparam int n      = 15;
  // x^4 + x + 1
  localparam int irrpol = 19;

  // one field element
  typedef logic [m-1:0] data_t;

  // shift and add product, reduced after every shift
  function automatic data_t gf_mult_a_by_b(data_t a, data_t b);
    data_t acc;
    data_t sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < m; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      // x^m folds back into the low bits of irrpol
      sh = sh[m-1] ? ((sh << 1) ^ data_t'(irrpol)) : (sh << 1);
    end
    return acc;
  endfunction

  // alpha^p, p taken modulo n, negative powers allowed
  function automatic data_t gf_alpha_pow(int p);
    int    e;
    data_t acc;
    e = p % n;
    if (e < 0) begin
      e = e + n;
    end
    acc = data_t'(1);
    for (int i = 0; i < n; i++) begin
      if (i < e) begin
        acc = gf_mult_a_by_b(acc, data_t'(2));
      end
    end
    return acc;
  endfunction

endpackage

/* design/bch_pkg.sv */
//------------------------------
// BCH(15,5) code definitions
// word, pointer and count types
//------------------------------
package bch_pkg;

  // correction capability, d = 2t + 1
  localparam int t     = 3;
  localparam int t2    = 2 * t;
  // message bits per word
  localparam int k_max = 5;

  // tag of a word in flight, selects the chien buffer entry
  typedef logic [0:0] ptr_t;

  // bit i is the coefficient of x^i
  typedef logic [gf_pkg::n-1:0] word_t;

  // corrected bit count, 0 .. n
  typedef logic [$clog2(gf_pkg::n + 1)-1:0] cnt_t;

endpackage

/* design/bch_eras_syndrome.sv */
//------------------------------
// erasure fill and syndrome unit
// zero and one filled trial words
// 2t syndromes per trial word
//------------------------------
`timescale 1ns/1ps

module bch_eras_syndrome (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           ival,
  input  bch_pkg::word_t idat,
  input  bch_pkg::word_t ieras,
  output logic           osyndrome_val,
  output bch_pkg::ptr_t  osyndrome_ptr,
  output gf_pkg::data_t  osyndrome [2][1:bch_pkg::t2],
  output bch_pkg::word_t oword_fill0,
  output bch_pkg::word_t oword_fill1
);

  import gf_pkg::*;
  import bch_pkg::*;

  // trial words, index 0 is the zero fill
  word_t fill [2];
  // syndromes of both trial words
  data_t syn  [2][1:t2];

  assign fill[0] = idat & ~ieras;
  assign fill[1] = idat | ieras;

  //------------------------------
  // syndrome evaluation
  //------------------------------

  // S_j = r(alpha^j), sum of alpha^(i*j) over set bits
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      for (int j = 1; j <= t2; j++) begin
        syn[w][j] = '0;
        for (int i = 0; i < n; i++) begin
          if (fill[w][i]) begin
            syn[w][j] = syn[w][j] ^ gf_alpha_pow(i * j);
          end
        end
      end
    end
  end

  //------------------------------
  // output registers
  //------------------------------

  // strobe and toggling pointer
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      osyndrome_val <= 1'b0;
      osyndrome_ptr <= '0;
    end else if (iclkena) begin
      osyndrome_val <= ival;
      // new tag per accepted word
      if (ival) begin
        osyndrome_ptr <= ~osyndrome_ptr;
      end
    end
  end

  // syndromes and trial words
  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      osyndrome   <= syn;
      oword_fill0 <= fill[0];
      oword_fill1 <= fill[1];
    end
  end

endmodule

/* design/bch_eras_berlekamp_ribm_1t.sv */
//------------------------------
// two pass inversionless Berlekamp-Massey
// binary form, t steps per syndrome set
// two locator polynomials per pointer
//------------------------------
`timescale 1ns/1ps

module bch_eras_berlekamp_ribm_1t (
  input  logic          iclk,
  input  logic          ireset,
  input  logic          iclkena,
  input  logic          isyndrome_val,
  input  bch_pkg::ptr_t isyndrome_ptr,
  input  gf_pkg::data_t isyndrome [2][1:bch_pkg::t2],
  output logic          ordy,
  output logic          oloc_poly_val,
  output bch_pkg::ptr_t oloc_poly_ptr,
  output gf_pkg::data_t oloc_poly [2][0:bch_pkg::t]
);

  import gf_pkg::*;
  import bch_pkg::*;

  typedef enum logic [1:0] {
    WAIT_S,
    STEP1_S,
    RELOAD_S,
    STEP2_S
  } state_t;

  typedef logic [$clog2(t)-1:0] step_cnt_t;

  state_t    state;
  step_cnt_t cnt;
  logic      cnt_done;
  int        step;

  // syndromes in use and the second set waiting
  data_t syn      [1:t2];
  data_t syn_hold [1:t2];
  ptr_t  ptr;

  // locator, correction poly, last discrepancy, length offset
  data_t lambda [0:t];
  data_t bpoly  [0:t];
  data_t gamma;
  logic signed [$clog2(t2 + 1):0] kv;

  // pass 0 result
  data_t loc0 [0:t];

  // next step values
  data_t delta;
  logic  upd;
  data_t lambda_nx [0:t];
  data_t bpoly_nx  [0:t];

  //------------------------------
  // FSM
  //------------------------------

  assign cnt_done = (cnt == '0);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state         <= WAIT_S;
      cnt           <= '0;
      oloc_poly_val <= 1'b0;
    end else if (iclkena) begin
      // last step of pass 2
      oloc_poly_val <= (state == STEP2_S) && cnt_done;
      case (state)
        WAIT_S: begin
          if (isyndrome_val) begin
            state <= STEP1_S;
            cnt   <= step_cnt_t'(t - 1);
          end
        end
        STEP1_S: begin
          if (cnt_done) begin
            state <= RELOAD_S;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        RELOAD_S: begin
          state <= STEP2_S;
          cnt   <= step_cnt_t'(t - 1);
        end
        STEP2_S: begin
          if (cnt_done) begin
            state <= WAIT_S;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= WAIT_S;
      endcase
    end
  end

  //------------------------------
  // one step of the recursion
  //------------------------------

  always_comb begin
    // step i uses S(2i+1-j) against lambda_j
    step  = (t - 1) - int'(cnt);
    delta = '0;
    for (int k = 1; k <= t2; k++) begin
      for (int j = 0; j <= t; j++) begin
        if (k == 2 * step + 1 - j) begin
          delta = delta ^ gf_mult_a_by_b(lambda[j], syn[k]);
        end
      end
    end
    // length change only for a nonzero discrepancy
    upd = (delta != '0) && (kv >= 0);
    // lambda = gamma * lambda + delta * x * B
    lambda_nx[0] = gf_mult_a_by_b(gamma, lambda[0]);
    for (int j = 1; j <= t; j++) begin
      lambda_nx[j] = gf_mult_a_by_b(gamma, lambda[j]) ^ gf_mult_a_by_b(delta, bpoly[j-1]);
    end
    // B = x * lambda or x^2 * B, even step folded in
    bpoly_nx[0] = '0;
    bpoly_nx[1] = upd ? lambda[0] : '0;
    for (int j = 2; j <= t; j++) begin
      bpoly_nx[j] = upd ? lambda[j-1] : bpoly[j-2];
    end
  end

  //------------------------------
  // datapath registers
  //------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // capture both sets and the tag
      if (state == WAIT_S && isyndrome_val) begin
        ptr      <= isyndrome_ptr;
        syn      <= isyndrome[0];
        syn_hold <= isyndrome[1];
      end
      if ((state == WAIT_S && isyndrome_val) || state == RELOAD_S) begin
        // lambda = B = 1
        for (int j = 0; j <= t; j++) begin
          lambda[j] <= (j == 0) ? data_t'(1) : '0;
          bpoly[j]  <= (j == 0) ? data_t'(1) : '0;
        end
        gamma <= data_t'(1);
        kv    <= '0;
      end else if (state == STEP1_S || state == STEP2_S) begin
        lambda <= lambda_nx;
        bpoly  <= bpoly_nx;
        if (upd) begin
          gamma <= delta;
          kv    <= -kv;
        end else begin
          kv <= kv + 2;
        end
      end
      // switch to fill 1, park fill 0 locator
      if (state == RELOAD_S) begin
        syn  <= syn_hold;
        loc0 <= lambda;
      end
    end
  end

  //------------------------------
  // outputs
  //------------------------------

  assign ordy          = (state == WAIT_S);
  assign oloc_poly_ptr = ptr;

  // lambda stays put in wait until the next set
  always_comb begin
    oloc_poly[0] = loc0;
    oloc_poly[1] = lambda;
  end

endmodule

/* design/bch_eras_chien.sv */
//------------------------------
// trial word buffer, two entries
// parallel chien search on both locators
// candidate selection
//------------------------------
`timescale 1ns/1ps

module bch_eras_chien (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           iword_val,
  input  bch_pkg::ptr_t  iword_ptr,
  input  bch_pkg::word_t iword_fill0,
  input  bch_pkg::word_t iword_fill1,
  input  logic           iloc_poly_val,
  input  bch_pkg::ptr_t  iloc_poly_ptr,
  input  gf_pkg::data_t  iloc_poly [2][0:bch_pkg::t],
  output logic           oval,
  output logic           ofail,
  output bch_pkg::word_t odat,
  output bch_pkg::cnt_t  oerr_cnt
);

  import gf_pkg::*;
  import bch_pkg::*;

  // buffer per fill, indexed by pointer
  word_t wbuf0 [2];
  word_t wbuf1 [2];

  word_t base  [2];
  word_t cand  [2];
  cnt_t  roots [2];
  cnt_t  deg   [2];
  logic  valid [2];
  logic  pick1;

  always_ff @(posedge iclk) begin
    if (iclkena && iword_val) begin
      wbuf0[iword_ptr] <= iword_fill0;
      wbuf1[iword_ptr] <= iword_fill1;
    end
  end

  assign base[0] = wbuf0[iloc_poly_ptr];
  assign base[1] = wbuf1[iloc_poly_ptr];

  //------------------------------
  // chien search
  //------------------------------

  always_comb begin
    data_t ev;
    for (int c = 0; c < 2; c++) begin
      cand[c]  = base[c];
      roots[c] = '0;
      deg[c]   = '0;
      // root at alpha^-i marks an error at bit i
      for (int i = 0; i < n; i++) begin
        ev = '0;
        for (int j = 0; j <= t; j++) begin
          ev = ev ^ gf_mult_a_by_b(iloc_poly[c][j], gf_alpha_pow(-i * j));
        end
        if (ev == '0) begin
          cand[c][i] = ~base[c][i];
          roots[c]   = roots[c] + 1'b1;
        end
      end
      // highest nonzero coefficient
      for (int j = 1; j <= t; j++) begin
        if (iloc_poly[c][j] != '0) begin
          deg[c] = cnt_t'(j);
        end
      end
      // every root found, so the locator splits
      valid[c] = (roots[c] == deg[c]);
    end
  end

  // fewer corrections wins, fill 0 on a tie
  assign pick1 = valid[1] && (!valid[0] || (roots[1] < roots[0]));

  //------------------------------
  // output registers
  //------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= iloc_poly_val;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && iloc_poly_val) begin
      if (!valid[0] && !valid[1]) begin
        // no candidate, pass fill 0 through
        ofail    <= 1'b1;
        odat     <= base[0];
        oerr_cnt <= '0;
      end else if (pick1) begin
        ofail    <= 1'b0;
        odat     <= cand[1];
        oerr_cnt <= roots[1];
      end else begin
        ofail    <= 1'b0;
        odat     <= cand[0];
        oerr_cnt <= roots[0];
      end
    end
  end

endmodule

/* design/bch_eras_decoder.sv */
//------------------------------
// BCH(15,5) erasure decoder top
// syndrome, berlekamp and chien stages
//------------------------------
`timescale 1ns/1ps

module bch_eras_decoder (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           ival,
  input  bch_pkg::word_t idat,
  input  bch_pkg::word_t ieras,
  output logic           ordy,
  output logic           oval,
  output logic           ofail,
  output bch_pkg::word_t odat,
  output bch_pkg::cnt_t  oerr_cnt
);

  import gf_pkg::*;
  import bch_pkg::*;

  logic  accept;

  // syndrome unit to berlekamp and chien buffer
  logic  syn_val;
  ptr_t  syn_ptr;
  data_t syn [2][1:t2];
  word_t fill0;
  word_t fill1;

  // berlekamp to chien
  logic  bm_rdy;
  logic  loc_val;
  ptr_t  loc_ptr;
  data_t loc [2][0:t];

  // hold off while a syndrome set waits for berlekamp
  assign ordy   = bm_rdy & ~syn_val;
  assign accept = ival & ordy;

  bch_eras_syndrome i_syndrome (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .ival          (accept),
    .idat          (idat),
    .ieras         (ieras),
    .osyndrome_val (syn_val),
    .osyndrome_ptr (syn_ptr),
    .osyndrome     (syn),
    .oword_fill0   (fill0),
    .oword_fill1   (fill1)
  );

  bch_eras_berlekamp_ribm_1t i_berlekamp (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .isyndrome_val (syn_val),
    .isyndrome_ptr (syn_ptr),
    .isyndrome     (syn),
    .ordy          (bm_rdy),
    .oloc_poly_val (loc_val),
    .oloc_poly_ptr (loc_ptr),
    .oloc_poly     (loc)
  );

  bch_eras_chien i_chien (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .iword_val     (syn_val),
    .iword_ptr     (syn_ptr),
    .iword_fill0   (fill0),
    .iword_fill1   (fill1),
    .iloc_poly_val (loc_val),
    .iloc_poly_ptr (loc_ptr),
    .iloc_poly     (loc),
    .oval          (oval),
    .ofail         (ofail),
    .odat          (odat),
    .oerr_cnt      (oerr_cnt)
  );

endmodule

/* tb/bch_clkgen.sv */
//------------------------------
// testbench clock and reset
// 40 ns period, 5 cycle reset
//------------------------------
`timescale 1ns/1ps

module bch_clkgen (
  output logic iclk,
  output logic ireset
);

  localparam int half_period  = 20;
  localparam int reset_cycles = 5;

  // free running clock
  initial begin
    iclk = 1'b0;
    forever #half_period iclk = ~iclk;
  end

  // reset drops just after the fifth rising edge
  initial begin
    ireset = 1'b1;
    repeat (reset_cycles) @(posedge iclk);
    #2;
    ireset = 1'b0;
  end

endmodule

/* tb/tb_bch_eras_decoder.sv */
//------------------------------
// BCH(15,5) erasure decoder testbench
// random stimulus, reference encoder and decoder model
// compare process, timeout and result line
//------------------------------
`timescale 1ns/1ps

module tb_bch_eras_decoder;

  import gf_pkg::*;
  import bch_pkg::*;

  // words per test group
  localparam int n_clean    = 8;
  localparam int n_err      = 30;
  localparam int n_eras     = 30;
  localparam int n_mix      = 40;
  localparam int n_ce       = 2;
  localparam int n_words    = n_clean + n_err + n_eras + n_mix + n_ce;
  localparam int max_cycles = n_words * 14 + 200;
  // longest wait for the last result, a few decoder latencies
  localparam int drain_cycles = 4 * (2 * t + 4);
  // g(x) of the code
  localparam logic [10:0] gen_poly = 11'h537;

  logic  iclk;
  logic  ireset;
  logic  iclkena;
  logic  ival;
  word_t idat;
  word_t ieras;
  logic  ordy;
  logic  oval;
  logic  ofail;
  word_t odat;
  cnt_t  oerr_cnt;

  logic [31:0] rng;
  int          value_errors;
  int          protocol_errors;
  int          cycles;
  logic        last_ena;

  // expected results in acceptance order
  word_t exp_dat_q  [$];
  cnt_t  exp_cnt_q  [$];
  logic  exp_fail_q [$];

  bch_clkgen i_clkgen (
    .iclk   (iclk),
    .ireset (ireset)
  );

  bch_eras_decoder i_bch_eras_decoder (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ival     (ival),
    .idat     (idat),
    .ieras    (ieras),
    .ordy     (ordy),
    .oval     (oval),
    .ofail    (ofail),
    .odat     (odat),
    .oerr_cnt (oerr_cnt)
  );

  //------------------------------
  // random numbers and reference
  //------------------------------

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // count distinct positions, none inside avoid
  function automatic word_t rand_mask(int count, word_t avoid);
    word_t mask;
    int    pos;
    mask = '0;
    while ($countones(mask) < count) begin
      pos = int'(next_rand() % 32'd15);
      if (!avoid[pos]) begin
        mask[pos] = 1'b1;
      end
    end
    return mask;
  endfunction

  // codeword = m(x) * g(x) over GF(2)
  function automatic word_t encode(logic [k_max-1:0] msg);
    word_t cw;
    cw = '0;
    for (int i = 0; i < k_max; i++) begin
      if (msg[i]) begin
        cw = cw ^ (word_t'(gen_poly) << i);
      end
    end
    return cw;
  endfunction

  // expected result for 2e+f within the design distance
  function automatic void predict_result(input word_t cw, input word_t rx, input word_t er,
                                         output word_t exp_dat, output cnt_t exp_cnt,
                                         output logic exp_fail);
    word_t f0;
    word_t f1;
    int    d0;
    int    d1;
    f0 = rx & ~er;
    f1 = rx | er;
    d0 = $countones(cw ^ f0);
    d1 = $countones(cw ^ f1);
    exp_dat  = cw;
    exp_fail = 1'b0;
    // closer trial word, zero fill on a tie
    exp_cnt  = cnt_t'((d1 < d0) ? d1 : d0);
  endfunction

  //------------------------------
  // compare tasks
  //------------------------------

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%04h expected 0x%04h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
  endtask

  //------------------------------
  // stimulus
  //------------------------------

  // offer a word and hold it until ordy takes it
  task automatic send_word(input word_t rx, input word_t er, input word_t exp_dat,
                           input cnt_t exp_cnt, input logic exp_fail);
    logic taken;
    ival  = 1'b1;
    idat  = rx;
    ieras = er;
    taken = 1'b0;
    while (!taken) begin
      @(negedge iclk);
      taken = ordy && iclkena;
      if (taken) begin
        exp_dat_q.push_back(exp_dat);
        exp_cnt_q.push_back(exp_cnt);
        exp_fail_q.push_back(exp_fail);
      end
      @(posedge iclk);
      #2;
    end
    ival = 1'b0;
    // busy right after the accepting edge
    @(negedge iclk);
    check_bit("ordy", ordy, 1'b0);
    @(posedge iclk);
    #2;
  endtask

  // e flipped bits, f erased bits with random fill
  task automatic run_word(input int e, input int f);
    logic [31:0] r;
    word_t       cw;
    word_t       emask;
    word_t       fmask;
    word_t       rx;
    word_t       exp_dat;
    cnt_t        exp_cnt;
    logic        exp_fail;
    r     = next_rand();
    cw    = encode(r[k_max-1:0]);
    emask = rand_mask(e, '0);
    fmask = rand_mask(f, emask);
    r     = next_rand();
    rx    = cw ^ emask;
    rx    = (rx & ~fmask) | (r[n-1:0] & fmask);
    predict_result(cw, rx, fmask, exp_dat, exp_cnt, exp_fail);
    send_word(rx, fmask, exp_dat, exp_cnt, exp_fail);
  endtask

  //------------------------------
  // compare process and timeout
  //------------------------------

  // a result counts only on an edge with iclkena high
  always @(negedge iclk) begin
    if (oval && last_ena) begin
      if (exp_dat_q.size() == 0) begin
        $display("oval went high at %0t with no word waiting for a result", $time);
        protocol_errors++;
      end else begin
        check_word("odat", odat, exp_dat_q.pop_front());
        check_cnt("oerr_cnt", oerr_cnt, exp_cnt_q.pop_front());
        check_bit("ofail", ofail, exp_fail_q.pop_front());
      end
    end
    last_ena = iclkena;
  end

  always @(posedge iclk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      protocol_errors++;
      print_counts();
      $display("Result: FAILED");
      $finish;
    end
  end

  //------------------------------
  // test sequence
  //------------------------------

  initial begin
    int e;
    int f;
    int wait_cycles;
    ival            = 1'b0;
    idat            = '0;
    ieras           = '0;
    iclkena         = 1'b1;
    rng             = 32'h8fbe5339;
    value_errors    = 0;
    protocol_errors = 0;
    cycles          = 0;
    last_ena        = 1'b0;
    wait (ireset === 1'b1);
    wait (ireset === 1'b0);
    // idle state after reset
    @(negedge iclk);
    check_bit("oval", oval, 1'b0);
    check_bit("ordy", ordy, 1'b1);
    @(posedge iclk);
    #2;
    // clean codewords
    for (int i = 0; i < n_clean; i++) begin
      run_word(0, 0);
    end
    // errors only, back to back so words wait on ordy
    for (int i = 0; i < n_err; i++) begin
      run_word(1 + int'(next_rand() % 32'd3), 0);
    end
    // erasures only
    for (int i = 0; i < n_eras; i++) begin
      run_word(0, 1 + int'(next_rand() % 32'd6));
    end
    // mixed, 2e+f up to 6
    for (int i = 0; i < n_mix; i++) begin
      e = int'(next_rand() % 32'd4);
      f = int'(next_rand() % 32'(7 - 2 * e));
      run_word(e, f);
    end
    // freeze the pipeline in the middle of a decode
    run_word(1, 2);
    repeat (2) @(posedge iclk);
    #2;
    iclkena = 1'b0;
    repeat (8) begin
      @(negedge iclk);
      check_bit("oval", oval, 1'b0);
    end
    @(posedge iclk);
    #2;
    iclkena = 1'b1;
    run_word(2, 0);
    // drain with a bound, then watch for stray strobes
    wait_cycles = 0;
    while (exp_dat_q.size() != 0 && wait_cycles < drain_cycles) begin
      @(posedge iclk);
      wait_cycles++;
    end
    repeat (20) @(posedge iclk);
    if (exp_dat_q.size() != 0) begin
      $display("%0d accepted words never produced a result", exp_dat_q.size());
      protocol_errors += exp_dat_q.size();
    end
    print_counts();
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
design/gf_pkg.sv
design/bch_pkg.sv
design/bch_eras_syndrome.sv
design/bch_eras_berlekamp_ribm_1t.sv
design/bch_eras_chien.sv
design/bch_eras_decoder.sv
tb/bch_clkgen.sv
tb/tb_bch_eras_decoder.sv

/* run.sh */
#!/bin/sh
# build and run the BCH(15,5) erasure decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_bch_eras_decoder \
  -f all.f -o sim_bch
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_bch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0
